// ==== source/comp_engine_pkg.sv ====
package comp_engine_pkg;

    // ------------------------------
    // bus and block geometry
    // ------------------------------
    localparam int ADDR_W      = 32;
    localparam int BUS_DATA_W  = 32;
    localparam int COMP_DATA_W = 64;
    localparam int BURST_BEATS = 16;
    localparam int BLK_BYTES   = 128;
    localparam int CBLK_BYTES  = 64;
    localparam int NUM_COMP    = 3;

    // derived widths
    localparam int BEAT_IDX_W  = $clog2(BURST_BEATS);
    localparam int BUF_ADDR_W  = $clog2(CBLK_BYTES / (COMP_DATA_W / 8));
    localparam int BLK_CNT_W   = ADDR_W - $clog2(BLK_BYTES);

    // AHB transfer codes
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // ------------------------------
    // shared types
    // ------------------------------
    typedef logic [BLK_CNT_W-1:0] blk_cnt_t;
    typedef logic [$clog2(NUM_COMP)-1:0] comp_sel_t;

    // master to slave
    typedef struct packed {
        logic                  hbusreq;
        logic [ADDR_W-1:0]     haddr;
        logic [1:0]            htrans;
        logic                  hwrite;
        logic [BUS_DATA_W-1:0] hwdata;
    } ahb_req_t;

    // slave and arbiter to master
    typedef struct packed {
        logic                  hgrant;
        logic                  hready;
        logic [BUS_DATA_W-1:0] hrdata;
    } ahb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
    } burst_cmd_t;

    // stream into the compressors
    typedef struct packed {
        logic                   wren;
        logic                   sop;
        logic                   eop;
        logic [COMP_DATA_W-1:0] wdata;
    } comp_wr_t;

    typedef struct packed {
        logic [NUM_COMP-1:0] done;
        logic [NUM_COMP-1:0] fail;
    } comp_status_t;

endpackage

// ==== source/block_sequencer.sv ====
`timescale 1ns/1ps

module block_sequencer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [comp_engine_pkg::ADDR_W-1:0]  src_addr_i,
    input  logic [comp_engine_pkg::ADDR_W-1:0]  dst_addr_i,
    input  comp_engine_pkg::blk_cnt_t           len_i,
    input  logic                                start_i,
    input  comp_engine_pkg::comp_status_t       comp_status_i,
    input  logic                                burst_done_i,
    output logic                                burst_start_o,
    output comp_engine_pkg::burst_cmd_t         burst_cmd_o,
    output comp_engine_pkg::comp_sel_t          comp_sel_o,
    output logic                                done_o
);
    import comp_engine_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD1,
        S_RD2,
        S_COMP,
        S_WR
    } state_t;

    state_t     state, state_n;
    blk_cnt_t   blk_cnt, blk_cnt_n;
    blk_cnt_t   blk_next;
    logic       burst_start, burst_start_n;
    burst_cmd_t burst_cmd, burst_cmd_n;
    comp_sel_t  comp_sel, comp_sel_n;
    comp_sel_t  winner;

    assign blk_next = blk_cnt + 1'b1;

    // first compressor that did not fail, 0 if all failed
    always_comb begin
        winner = '0;
        for (int i = NUM_COMP - 1; i >= 0; i--) begin
            if (!comp_status_i.fail[i]) begin
                winner = comp_sel_t'(i);
            end
        end
    end

    always_comb begin
        state_n       = state;
        blk_cnt_n     = blk_cnt;
        burst_start_n = 1'b0;
        burst_cmd_n   = burst_cmd;
        comp_sel_n    = comp_sel;

        case (state)
            S_IDLE: begin
                if (start_i && len_i != '0) begin
                    blk_cnt_n     = '0;
                    burst_start_n = 1'b1;
                    burst_cmd_n   = '{addr: src_addr_i, write: 1'b0};
                    state_n       = S_RD1;
                end
            end
            S_RD1: begin
                // second half of the raw block
                if (burst_done_i) begin
                    burst_start_n = 1'b1;
                    burst_cmd_n.addr = burst_cmd.addr + ADDR_W'(BLK_BYTES / 2);
                    state_n       = S_RD2;
                end
            end
            S_RD2: begin
                if (burst_done_i) begin
                    state_n = S_COMP;
                end
            end
            S_COMP: begin
                if (&comp_status_i.done) begin
                    comp_sel_n    = winner;
                    burst_start_n = 1'b1;
                    burst_cmd_n.addr  = dst_addr_i + (ADDR_W'(blk_cnt) << $clog2(CBLK_BYTES));
                    burst_cmd_n.write = 1'b1;
                    state_n       = S_WR;
                end
            end
            default: begin
                if (burst_done_i) begin
                    blk_cnt_n = blk_next;
                    if (blk_next == len_i) begin
                        state_n = S_IDLE;
                    end else begin
                        burst_start_n     = 1'b1;
                        burst_cmd_n.addr  = src_addr_i
                                          + (ADDR_W'(blk_next) << $clog2(BLK_BYTES));
                        burst_cmd_n.write = 1'b0;
                        state_n           = S_RD1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            blk_cnt     <= '0;
            burst_start <= 1'b0;
            comp_sel    <= '0;
        end else begin
            state       <= state_n;
            blk_cnt     <= blk_cnt_n;
            burst_start <= burst_start_n;
            comp_sel    <= comp_sel_n;
        end
    end

    always_ff @(posedge clk) begin
        burst_cmd <= burst_cmd_n;
    end

    assign burst_start_o = burst_start;
    assign burst_cmd_o   = burst_cmd;
    assign comp_sel_o    = comp_sel;
    // a pending start already counts as busy
    assign done_o        = (state == S_IDLE) && !start_i;

endmodule

// ==== source/ahb_burst_master.sv ====
`timescale 1ns/1ps

module ahb_burst_master (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     burst_start_i,
    input  comp_engine_pkg::burst_cmd_t              burst_cmd_i,
    input  comp_engine_pkg::ahb_rsp_t                ahb_rsp_i,
    input  logic [comp_engine_pkg::BUS_DATA_W-1:0]   wr_word_i,
    output comp_engine_pkg::ahb_req_t                ahb_req_o,
    output logic                                     burst_done_o,
    output logic                                     rd_beat_o,
    output logic [comp_engine_pkg::BUS_DATA_W-1:0]   rd_data_o,
    output logic [comp_engine_pkg::BEAT_IDX_W-1:0]   wr_idx_o
);
    import comp_engine_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_BUSREQ,
        S_FIRST_ADDR,
        S_MIDDLE,
        S_LAST_DATA
    } state_t;

    localparam logic [BEAT_IDX_W-1:0] LAST_IDX = BEAT_IDX_W'(BURST_BEATS - 1);

    state_t                  state, state_n;
    burst_cmd_t              cmd, cmd_n;
    // writes count address phases, reads count data phases
    logic [BEAT_IDX_W-1:0]   beat_cnt, beat_cnt_n;
    logic [BEAT_IDX_W-1:0]   addr_idx;
    logic                    hbusreq, hbusreq_n;
    logic [ADDR_W-1:0]       haddr, haddr_n;
    logic [1:0]              htrans, htrans_n;
    logic                    hwrite, hwrite_n;
    logic [BUS_DATA_W-1:0]   hwdata, hwdata_n;

    // index of the address accepted in MIDDLE
    assign addr_idx = hwrite ? beat_cnt : beat_cnt + 1'b1;

    always_comb begin
        state_n    = state;
        cmd_n      = cmd;
        beat_cnt_n = beat_cnt;
        hbusreq_n  = hbusreq;
        haddr_n    = haddr;
        htrans_n   = htrans;
        hwrite_n   = hwrite;
        hwdata_n   = hwdata;

        case (state)
            S_IDLE: begin
                if (burst_start_i) begin
                    cmd_n     = burst_cmd_i;
                    hbusreq_n = 1'b1;
                    state_n   = S_BUSREQ;
                end
            end
            S_BUSREQ: begin
                if (ahb_rsp_i.hgrant && ahb_rsp_i.hready) begin
                    haddr_n    = cmd.addr;
                    htrans_n   = HTRANS_NONSEQ;
                    hwrite_n   = cmd.write;
                    beat_cnt_n = '0;
                    state_n    = S_FIRST_ADDR;
                end
            end
            S_FIRST_ADDR: begin
                // first address accepted, no data yet
                if (ahb_rsp_i.hready) begin
                    haddr_n  = haddr + ADDR_W'(4);
                    htrans_n = HTRANS_SEQ;
                    if (hwrite) begin
                        hwdata_n   = wr_word_i;
                        beat_cnt_n = beat_cnt + 1'b1;
                    end
                    state_n = S_MIDDLE;
                end
            end
            S_MIDDLE: begin
                // one address and one data phase per accepted cycle
                if (ahb_rsp_i.hready) begin
                    if (hwrite) begin
                        hwdata_n = wr_word_i;
                    end
                    if (addr_idx == LAST_IDX - 1'b1) begin
                        hbusreq_n = 1'b0;
                    end
                    if (addr_idx == LAST_IDX) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_LAST_DATA;
                    end else begin
                        haddr_n    = haddr + ADDR_W'(4);
                        beat_cnt_n = beat_cnt + 1'b1;
                    end
                end
            end
            default: begin
                if (ahb_rsp_i.hready) begin
                    state_n = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
            hbusreq  <= 1'b0;
            htrans   <= HTRANS_IDLE;
            hwrite   <= 1'b0;
        end else begin
            state    <= state_n;
            beat_cnt <= beat_cnt_n;
            hbusreq  <= hbusreq_n;
            htrans   <= htrans_n;
            hwrite   <= hwrite_n;
        end
    end

    always_ff @(posedge clk) begin
        cmd    <= cmd_n;
        haddr  <= haddr_n;
        hwdata <= hwdata_n;
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign ahb_req_o = '{hbusreq: hbusreq, haddr: haddr, htrans: htrans,
                         hwrite: hwrite, hwdata: hwdata};

    assign burst_done_o = (state == S_LAST_DATA) && ahb_rsp_i.hready;
    assign rd_beat_o    = (state == S_MIDDLE || state == S_LAST_DATA)
                        && ahb_rsp_i.hready && !hwrite;
    assign rd_data_o    = ahb_rsp_i.hrdata;
    assign wr_idx_o     = beat_cnt;

endmodule

// ==== source/rd_beat_packer.sv ====
`timescale 1ns/1ps

module rd_beat_packer (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     rd_beat_i,
    input  logic [comp_engine_pkg::BUS_DATA_W-1:0]   rd_data_i,
    output comp_engine_pkg::comp_wr_t                comp_wr_o
);
    import comp_engine_pkg::*;

    // 32 beats per block, wraps at the block boundary
    logic [4:0]                   beat_cnt;
    logic [BUS_DATA_W-1:0]        upper_q;
    logic                         wren_q;
    logic                         sop_q;
    logic                         eop_q;
    logic [COMP_DATA_W-1:0]       wdata_q;
    logic                         odd_beat;

    assign odd_beat = beat_cnt[0];

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            wren_q   <= 1'b0;
            sop_q    <= 1'b0;
            eop_q    <= 1'b0;
        end else begin
            wren_q <= rd_beat_i && odd_beat;
            sop_q  <= rd_beat_i && odd_beat && (beat_cnt[4:1] == 4'd0);
            eop_q  <= rd_beat_i && odd_beat && (beat_cnt[4:1] == 4'd15);
            if (rd_beat_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rd_beat_i && !odd_beat) begin
            upper_q <= rd_data_i;
        end
        if (rd_beat_i && odd_beat) begin
            wdata_q <= {upper_q, rd_data_i};
        end
    end

    assign comp_wr_o = '{wren: wren_q, sop: sop_q, eop: eop_q, wdata: wdata_q};

endmodule

// ==== source/wr_beat_unpacker.sv ====
`timescale 1ns/1ps

module wr_beat_unpacker (
    input  logic [comp_engine_pkg::BEAT_IDX_W-1:0]   wr_idx_i,
    input  comp_engine_pkg::comp_sel_t               comp_sel_i,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp0_rdata_i,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp1_rdata_i,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp2_rdata_i,
    output logic [comp_engine_pkg::BUS_DATA_W-1:0]   wr_word_o,
    output logic [comp_engine_pkg::BUF_ADDR_W-1:0]   buf_addr_o
);
    import comp_engine_pkg::*;

    logic [COMP_DATA_W-1:0] entry;

    // winning compressor's buffer entry
    always_comb begin
        case (comp_sel_i)
            comp_sel_t'(1): entry = comp1_rdata_i;
            comp_sel_t'(2): entry = comp2_rdata_i;
            default:        entry = comp0_rdata_i;
        endcase
    end

    // two bus words per entry
    assign buf_addr_o = wr_idx_i[BEAT_IDX_W-1:1];

    // even index takes the upper half
    assign wr_word_o  = wr_idx_i[0] ? entry[BUS_DATA_W-1:0]
                                    : entry[COMP_DATA_W-1:BUS_DATA_W];

endmodule

// ==== source/comp_engine_top.sv ====
`timescale 1ns/1ps

module comp_engine_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [comp_engine_pkg::ADDR_W-1:0]       src_addr_i,
    input  logic [comp_engine_pkg::ADDR_W-1:0]       dst_addr_i,
    input  comp_engine_pkg::blk_cnt_t                len_i,
    input  logic                                     start_i,
    output logic                                     done_o,
    input  comp_engine_pkg::ahb_rsp_t                ahb_rsp_i,
    output comp_engine_pkg::ahb_req_t                ahb_req_o,
    output comp_engine_pkg::comp_wr_t                comp_wr_o,
    input  comp_engine_pkg::comp_status_t            comp_status_i,
    output logic [comp_engine_pkg::BUF_ADDR_W-1:0]   buf_addr_o,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp0_rdata_i,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp1_rdata_i,
    input  logic [comp_engine_pkg::COMP_DATA_W-1:0]  comp2_rdata_i
);
    import comp_engine_pkg::*;

    logic                   burst_start;
    burst_cmd_t             burst_cmd;
    logic                   burst_done;
    comp_sel_t              comp_sel;
    logic                   rd_beat;
    logic [BUS_DATA_W-1:0]  rd_data;
    logic [BEAT_IDX_W-1:0]  wr_idx;
    logic [BUS_DATA_W-1:0]  wr_word;

    block_sequencer block_sequencer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr_i),
        .dst_addr_i    (dst_addr_i),
        .len_i         (len_i),
        .start_i       (start_i),
        .comp_status_i (comp_status_i),
        .burst_done_i  (burst_done),
        .burst_start_o (burst_start),
        .burst_cmd_o   (burst_cmd),
        .comp_sel_o    (comp_sel),
        .done_o        (done_o)
    );

    ahb_burst_master ahb_burst_master_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .burst_start_i (burst_start),
        .burst_cmd_i   (burst_cmd),
        .ahb_rsp_i     (ahb_rsp_i),
        .wr_word_i     (wr_word),
        .ahb_req_o     (ahb_req_o),
        .burst_done_o  (burst_done),
        .rd_beat_o     (rd_beat),
        .rd_data_o     (rd_data),
        .wr_idx_o      (wr_idx)
    );

    rd_beat_packer rd_beat_packer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_beat_i (rd_beat),
        .rd_data_i (rd_data),
        .comp_wr_o (comp_wr_o)
    );

    wr_beat_unpacker wr_beat_unpacker_inst (
        .wr_idx_i      (wr_idx),
        .comp_sel_i    (comp_sel),
        .comp0_rdata_i (comp0_rdata_i),
        .comp1_rdata_i (comp1_rdata_i),
        .comp2_rdata_i (comp2_rdata_i),
        .wr_word_o     (wr_word),
        .buf_addr_o    (buf_addr_o)
    );

endmodule

// ==== sim/comp_engine_assertions.sv ====
`timescale 1ns/1ps

module comp_engine_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input comp_engine_pkg::ahb_req_t ahb_req,
    input comp_engine_pkg::ahb_rsp_t ahb_rsp,
    input comp_engine_pkg::comp_wr_t comp_wr,
    input logic                      done
);
    import comp_engine_pkg::*;

    // last address accepted on the bus
    logic [ADDR_W-1:0] last_addr;

    always_ff @(posedge clk) begin
        if (ahb_rsp.hready && ahb_req.htrans[1]) begin
            last_addr <= ahb_req.haddr;
        end
    end

    seq_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        (ahb_rsp.hready && ahb_req.htrans == HTRANS_SEQ) |-> ahb_req.haddr == last_addr + 4)
        else $error("SEQ address is not the previous address plus 4");

    bus_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!ahb_req.hbusreq && ahb_req.htrans == HTRANS_IDLE))
        else $error("bus not idle after reset");

    sop_eop_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(comp_wr.sop && comp_wr.eop))
        else $error("sop and eop set together");

    busy_while_bus_active: assert property (@(posedge clk) disable iff (!rst_n)
        (ahb_req.htrans != HTRANS_IDLE) |-> !done)
        else $error("done_o high during a bus transfer");

endmodule

bind comp_engine_top comp_engine_assertions comp_engine_assertions_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ahb_req (ahb_req_o),
    .ahb_rsp (ahb_rsp_i),
    .comp_wr (comp_wr_o),
    .done    (done_o)
);

// ==== sim/comp_engine_tb.sv ====
`timescale 1ns/1ps

module comp_engine_tb;
    import comp_engine_pkg::*;

    localparam logic [31:0] RD_KEY  = 32'h5a3c_96e1;
    localparam int          TIMEOUT = 5000;

    logic                   clk;
    logic                   rst_n;
    logic [ADDR_W-1:0]      src_addr;
    logic [ADDR_W-1:0]      dst_addr;
    blk_cnt_t               len;
    logic                   start;
    logic                   done;
    ahb_rsp_t               ahb_rsp;
    ahb_req_t               ahb_req;
    comp_wr_t               comp_wr;
    comp_status_t           comp_status;
    logic [BUF_ADDR_W-1:0]  buf_addr;
    logic [COMP_DATA_W-1:0] comp0_rdata;
    logic [COMP_DATA_W-1:0] comp1_rdata;
    logic [COMP_DATA_W-1:0] comp2_rdata;

    // model state
    logic [31:0]         rng = 32'd79;
    logic                stall_en;
    logic [NUM_COMP-1:0] fail_cfg;
    logic [NUM_COMP-1:0] done_q;
    int                  done_dly [NUM_COMP];
    int                  blk_seen;
    logic                dp_valid;
    logic                dp_write;
    logic [31:0]         dp_addr;
    logic [31:0]         rd_addr_q [$];
    logic [31:0]         wr_addr_q [$];
    logic [31:0]         wr_data_q [$];
    comp_wr_t            cw_q [$];
    int                  errors;
    int                  checks;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // output buffer contents per compressor, block and entry
    function automatic logic [63:0] buf_entry(input int c, input int blk, input int k);
        logic [31:0] s;
        s = xorshift32(32'(79 + c * 4099 + blk * 131 + k * 7));
        return {s, xorshift32(s)};
    endfunction

    function automatic int expected_winner(input logic [NUM_COMP-1:0] fail);
        for (int i = 0; i < NUM_COMP; i++) begin
            if (!fail[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    assign comp0_rdata = buf_entry(0, blk_seen - 1, int'(buf_addr));
    assign comp1_rdata = buf_entry(1, blk_seen - 1, int'(buf_addr));
    assign comp2_rdata = buf_entry(2, blk_seen - 1, int'(buf_addr));

    comp_engine_top comp_engine_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr),
        .dst_addr_i    (dst_addr),
        .len_i         (len),
        .start_i       (start),
        .done_o        (done),
        .ahb_rsp_i     (ahb_rsp),
        .ahb_req_o     (ahb_req),
        .comp_wr_o     (comp_wr),
        .comp_status_i (comp_status),
        .buf_addr_o    (buf_addr),
        .comp0_rdata_i (comp0_rdata),
        .comp1_rdata_i (comp1_rdata),
        .comp2_rdata_i (comp2_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // slave and compressor models
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            done_q   <= '0;
            blk_seen <= 0;
            for (int i = 0; i < NUM_COMP; i++) begin
                done_dly[i] <= 0;
            end
        end else begin
            if (ahb_rsp.hready) begin
                if (dp_valid && dp_write) begin
                    wr_addr_q.push_back(dp_addr);
                    wr_data_q.push_back(ahb_req.hwdata);
                end
                if (ahb_req.htrans[1] && !ahb_req.hwrite) begin
                    rd_addr_q.push_back(ahb_req.haddr);
                end
                dp_valid <= ahb_req.htrans[1];
                dp_addr  <= ahb_req.haddr;
                dp_write <= ahb_req.hwrite;
            end
            if (comp_wr.wren) begin
                cw_q.push_back(comp_wr);
            end
            if (comp_wr.wren && comp_wr.sop) begin
                blk_seen <= blk_seen + 1;
            end
            // done follows eop after 2, 3 and 4 cycles
            for (int i = 0; i < NUM_COMP; i++) begin
                if (comp_wr.wren && comp_wr.sop) begin
                    done_q[i]   <= 1'b0;
                    done_dly[i] <= 0;
                end else if (comp_wr.wren && comp_wr.eop) begin
                    done_dly[i] <= 2 + i;
                end else if (done_dly[i] == 1) begin
                    done_q[i]   <= 1'b1;
                    done_dly[i] <= 0;
                end else if (done_dly[i] > 1) begin
                    done_dly[i] <= done_dly[i] - 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        logic [31:0] r;
        r   = xorshift32(rng);
        rng = r;
        ahb_rsp.hready <= stall_en ? (r[1:0] != 2'b00) : 1'b1;
        ahb_rsp.hgrant <= stall_en ? (r[4:3] != 2'b00) : 1'b1;
        ahb_rsp.hrdata <= dp_addr ^ RD_KEY;
        comp_status    <= '{done: done_q, fail: fail_cfg};
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        start = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        cw_q.delete();
    endtask

    task automatic wait_done(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (done) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            errors++;
            $display("done_o did not return high within %0d cycles", TIMEOUT);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        apply_reset();
        compare("done_o", done, 1);
        compare("hbusreq", ahb_req.hbusreq, 0);
        compare("htrans", ahb_req.htrans, HTRANS_IDLE);
        compare("comp_wren", comp_wr.wren, 0);
        len   = '0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (3) @(negedge clk);
        compare("done_o", done, 1);
        compare("hbusreq", ahb_req.hbusreq, 0);
        $display("reset and zero length: %0d errors", errors - err0);
    endtask

    task automatic run_blocks(input string name, input int n_blk,
                              input logic [NUM_COMP-1:0] fail, input logic stalls);
        int          err0;
        bit          ok;
        int          w;
        logic [31:0] base;
        logic [63:0] ent;
        logic [63:0] exp_word;
        err0 = errors;
        apply_reset();
        fail_cfg = fail;
        stall_en = stalls;
        src_addr = 32'h0004_0000;
        dst_addr = 32'h0008_0100;
        len      = blk_cnt_t'(n_blk);
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(ok);
        if (ok) begin
            w = expected_winner(fail);
            compare("read count", rd_addr_q.size(), 32 * n_blk);
            compare("comp word count", cw_q.size(), 16 * n_blk);
            compare("write count", wr_addr_q.size(), 16 * n_blk);
            for (int b = 0; b < n_blk; b++) begin
                base = src_addr + 32'(128 * b);
                for (int i = 0; i < 32 && 32 * b + i < rd_addr_q.size(); i++) begin
                    compare("haddr read", rd_addr_q[32 * b + i], base + 32'(4 * i));
                end
                for (int k = 0; k < 16 && 16 * b + k < cw_q.size(); k++) begin
                    exp_word = {base + 32'(8 * k), base + 32'(8 * k + 4)} ^ {RD_KEY, RD_KEY};
                    compare("comp_wdata", cw_q[16 * b + k].wdata, exp_word);
                    compare("comp_sop", cw_q[16 * b + k].sop, k == 0);
                    compare("comp_eop", cw_q[16 * b + k].eop, k == 15);
                end
                for (int j = 0; j < 16 && 16 * b + j < wr_addr_q.size(); j++) begin
                    ent = buf_entry(w, b, j / 2);
                    compare("haddr write", wr_addr_q[16 * b + j],
                            dst_addr + 32'(64 * b + 4 * j));
                    compare("hwdata", wr_data_q[16 * b + j], j % 2 ? ent[31:0] : ent[63:32]);
                end
            end
        end
        $display("%s: %0d errors", name, errors - err0);
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        len         = '0;
        src_addr    = '0;
        dst_addr    = '0;
        stall_en    = 1'b0;
        fail_cfg    = '0;
        dp_valid    = 1'b0;
        dp_write    = 1'b0;
        dp_addr     = '0;
        ahb_rsp     = '{hgrant: 1'b1, hready: 1'b1, hrdata: '0};
        comp_status = '0;
        errors      = 0;
        checks      = 0;

        test_reset_state();
        run_blocks("one block, all succeed", 1, 3'b000, 1'b0);
        run_blocks("compressor 0 fails", 1, 3'b001, 1'b0);
        run_blocks("compressors 0 and 1 fail", 1, 3'b011, 1'b0);
        run_blocks("all compressors fail", 1, 3'b111, 1'b0);
        run_blocks("three blocks with stalls", 3, 3'b010, 1'b1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/comp_engine_pkg.sv
source/block_sequencer.sv
source/ahb_burst_master.sv
source/rd_beat_packer.sv
source/wr_beat_unpacker.sv
source/comp_engine_top.sv
sim/comp_engine_assertions.sv
sim/comp_engine_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= comp_engine_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
